// ==== hw/clkPkg.sv ====
package clkPkg;

  // Field widths
  localparam int diagSelW  = 3;
  localparam int rdDataW   = 6;
  localparam int ldDataW   = 4;
  localparam int burstW    = 8;
  localparam int cramTimeW = 2;
  localparam int rateW     = 2;

  // Diagnostic control functions, 00x group
  localparam logic [diagSelW-1:0] fnStart      = 3'd1;
  localparam logic [diagSelW-1:0] fnSingleStep = 3'd2;
  localparam logic [diagSelW-1:0] fnEboxSs     = 3'd3;
  localparam logic [diagSelW-1:0] fnBurst      = 3'd5;
  localparam logic [diagSelW-1:0] fnClrReset   = 3'd6;
  localparam logic [diagSelW-1:0] fnSetReset   = 3'd7;

  // Diagnostic load functions, 04x group
  localparam logic [diagSelW-1:0] ldBurstLo = 3'd2;
  localparam logic [diagSelW-1:0] ldBurstHi = 3'd3;
  localparam logic [diagSelW-1:0] ldRate    = 3'd4;
  localparam logic [diagSelW-1:0] ldSectDis = 3'd5;

  // EBUS towards the clock board
  typedef struct packed {
    // Function select, low three bits of ds
    logic [diagSelW-1:0] ds;
    // Control function strobe, one cycle
    logic                ctlFunc;
    // Load function strobe, one cycle
    logic                ldFunc;
    // Diagnostic read, held as a level
    logic                readFunc;
    // Load data nibble
    logic [ldDataW-1:0]  data;
  } ebusIn_t;

  // Readback driver onto the EBUS data field
  typedef struct packed {
    logic               driving;
    logic [rdDataW-1:0] data;
  } ebusOut_t;

  // Run state of the EBOX clock
  typedef struct packed {
    logic go;
    logic burst;
    logic eboxSs;
    logic mrReset;
  } runState_t;

  // Loaded configuration
  typedef struct packed {
    logic [rateW-1:0] rateSel;
    logic             crmDis;
    logic             edpDis;
    logic             ctlDis;
  } clkCfg_t;

  // Section clock enables
  typedef struct packed {
    logic crm;
    logic edp;
    logic ctl;
  } sectEn_t;

endpackage

// ==== hw/diagFuncRegs.sv ====
`timescale 1ns/1ps

module diagFuncRegs (
  input  logic                         MBOX_CLK,
  input  logic                         CLK,
  input  clkPkg::ebusIn_t              ebus,
  output clkPkg::runState_t            run,
  output clkPkg::clkCfg_t              cfg,
  output logic                         loadLo,
  output logic                         loadHi,
  output logic [clkPkg::ldDataW-1:0]   loadData,
  output logic                         stepPulse
);
  import clkPkg::*;

  // Decoded control functions
  logic funcStart;
  logic funcSingleStep;
  logic funcEboxSs;
  logic funcBurst;
  logic funcClrReset;
  logic funcSetReset;

  // Decoded load functions for the local registers
  logic loadRate;
  logic loadSectDis;

  // Control decode, strobes act directly
  assign funcStart      = ebus.ctlFunc & (ebus.ds == fnStart);
  assign funcSingleStep = ebus.ctlFunc & (ebus.ds == fnSingleStep);
  assign funcEboxSs     = ebus.ctlFunc & (ebus.ds == fnEboxSs);
  assign funcBurst      = ebus.ctlFunc & (ebus.ds == fnBurst);
  assign funcClrReset   = ebus.ctlFunc & (ebus.ds == fnClrReset);
  assign funcSetReset   = ebus.ctlFunc & (ebus.ds == fnSetReset);

  // Load decode, 042 to 045
  assign loadLo      = ebus.ldFunc & (ebus.ds == ldBurstLo);
  assign loadHi      = ebus.ldFunc & (ebus.ds == ldBurstHi);
  assign loadRate    = ebus.ldFunc & (ebus.ds == ldRate);
  assign loadSectDis = ebus.ldFunc & (ebus.ds == ldSectDis);

  // Burst nibbles go straight to the counter
  assign loadData = ebus.data;

  // GO, BURST and EBOX SS are reloaded together by any control function
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      run.go     <= 1'b0;
      run.burst  <= 1'b0;
      run.eboxSs <= 1'b0;
    end else if (ebus.ctlFunc) begin
      run.go     <= funcStart;
      run.burst  <= funcBurst;
      run.eboxSs <= funcEboxSs;
    end
  end

  // Master reset flip-flop, comes up set
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      run.mrReset <= 1'b1;
    end else if (funcClrReset) begin
      run.mrReset <= 1'b0;
    end else if (funcSetReset) begin
      run.mrReset <= 1'b1;
    end
  end

  // Rate select and section disables
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      cfg <= '0;
    end else begin
      if (loadRate) begin
        cfg.rateSel <= ebus.data[rateW-1:0];
      end
      // Disable bits sit in data bits 2 to 0
      if (loadSectDis) begin
        cfg.crmDis <= ebus.data[2];
        cfg.edpDis <= ebus.data[1];
        cfg.ctlDis <= ebus.data[0];
      end
    end
  end

  // Both step functions ask for one EBOX clock
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      stepPulse <= 1'b0;
    end else begin
      stepPulse <= funcSingleStep | funcEboxSs;
    end
  end

endmodule

// ==== hw/burstCounter.sv ====
`timescale 1ns/1ps

module burstCounter (
  input  logic                        MBOX_CLK,
  input  logic                        CLK,
  input  logic                        loadLo,
  input  logic                        loadHi,
  input  logic [clkPkg::ldDataW-1:0]  loadData,
  input  logic                        tick,
  input  logic                        burst,
  output logic [clkPkg::burstW-1:0]   burstCount,
  output logic                        burstZero
);
  import clkPkg::*;

  // Count after a nibble load
  logic [burstW-1:0] loLoaded;
  logic [burstW-1:0] hiLoaded;
  logic              countDown;

  assign loLoaded = {burstCount[burstW-1:ldDataW], loadData};
  assign hiLoaded = {loadData, burstCount[ldDataW-1:0]};

  // Never wraps below zero
  assign countDown = tick & burst & (burstCount != '0);

  // Zero flag follows loads and decrements only
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      burstCount <= '0;
      burstZero  <= 1'b0;
    end else if (loadLo) begin
      burstCount <= loLoaded;
      burstZero  <= (loLoaded == '0);
    end else if (loadHi) begin
      burstCount <= hiLoaded;
      burstZero  <= (hiLoaded == '0);
    end else if (countDown) begin
      burstCount <= burstCount - 1'b1;
      // Last clock of the burst
      burstZero  <= (burstCount == burstW'(1));
    end
  end

endmodule

// ==== hw/eboxSyncDetect.sv ====
`timescale 1ns/1ps

module eboxSyncDetect (
  input  logic                          MBOX_CLK,
  input  logic                          CLK,
  input  clkPkg::runState_t             run,
  input  clkPkg::clkCfg_t               cfg,
  input  logic                          stepPulse,
  input  logic                          burstZero,
  input  logic [clkPkg::cramTimeW-1:0]  cramTime,
  input  logic                          mboxWait,
  input  logic                          mboxResp,
  output logic                          tick,
  output logic                          eboxSync,
  output clkPkg::sectEn_t               sectClk
);
  import clkPkg::*;

  // Rate divider
  logic [rateW-1:0]     rateCnt;
  logic                 rateTick;

  // Step request waiting for a source tick
  logic                 stepPend;

  // MBOX phase counter and pending request
  logic                 reqPend;
  logic [cramTimeW-1:0] phase;
  logic                 syncHit;

  // EBOX clock cycle, one after sync
  logic                 clkCycle;
  logic                 idle;
  logic                 wantClk;

  // One rate tick every rateSel+1 cycles
  assign rateTick = (rateCnt >= cfg.rateSel);

  // Busy from source tick until the section enables
  assign idle = ~(reqPend | eboxSync | clkCycle);

  assign wantClk = run.go | (run.burst & ~burstZero) | stepPend;
  assign tick    = rateTick & idle & wantClk;

  // Phase reached the time field, MBOX wait holds unless answered
  assign syncHit = reqPend & (phase >= cramTime) & (~mboxWait | mboxResp);

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      rateCnt <= '0;
    end else if (rateTick) begin
      rateCnt <= '0;
    end else begin
      rateCnt <= rateCnt + 1'b1;
    end
  end

  // A new step wins over the tick that consumes the old one
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      stepPend <= 1'b0;
    end else if (stepPulse) begin
      stepPend <= 1'b1;
    end else if (tick) begin
      stepPend <= 1'b0;
    end
  end

  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      reqPend <= 1'b0;
      phase   <= '0;
    end else if (tick) begin
      reqPend <= 1'b1;
      phase   <= '0;
    end else begin
      if (syncHit) begin
        reqPend <= 1'b0;
      end
      // Saturates, compare is greater or equal
      if (reqPend && phase != '1) begin
        phase <= phase + 1'b1;
      end
    end
  end

  // Sync for one cycle, then the masked section enables
  always_ff @(posedge MBOX_CLK or posedge CLK) begin
    if (CLK) begin
      eboxSync <= 1'b0;
      clkCycle <= 1'b0;
      sectClk  <= '0;
    end else begin
      eboxSync    <= syncHit;
      clkCycle    <= eboxSync;
      sectClk.crm <= eboxSync & ~cfg.crmDis;
      sectClk.edp <= eboxSync & ~cfg.edpDis;
      sectClk.ctl <= eboxSync & ~cfg.ctlDis;
    end
  end

endmodule

// ==== hw/diagReadMux.sv ====
`timescale 1ns/1ps

module diagReadMux (
  input  clkPkg::ebusIn_t             ebus,
  input  clkPkg::runState_t           run,
  input  clkPkg::clkCfg_t             cfg,
  input  logic [clkPkg::burstW-1:0]   burstCount,
  input  logic                        burstZero,
  input  logic                        eboxSync,
  output clkPkg::ebusOut_t            ebusRd
);
  import clkPkg::*;

  // Word selected by ds, before the read gate
  logic [rdDataW-1:0] rdWord;

  always_comb begin
    case (ebus.ds)
      // Run state and status
      3'd0: rdWord = {run.go, run.burst, run.eboxSs, run.mrReset,
                      burstZero, eboxSync};
      // Burst count, high nibble
      3'd1: rdWord = {2'b00, burstCount[burstW-1:ldDataW]};
      // Burst count, low nibble
      3'd2: rdWord = {2'b00, burstCount[ldDataW-1:0]};
      // Rate and section disables
      3'd3: rdWord = {cfg.rateSel, cfg.crmDis, cfg.edpDis, cfg.ctlDis, 1'b0};
      default: rdWord = '0;
    endcase
  end

  // Drive the EBUS only during a diagnostic read
  always_comb begin
    if (ebus.readFunc) begin
      ebusRd.driving = 1'b1;
      ebusRd.data    = rdWord;
    end else begin
      ebusRd.driving = 1'b0;
      ebusRd.data    = '0;
    end
  end

endmodule

// ==== hw/clkBoard.sv ====
`timescale 1ns/1ps

module clkBoard (
  input  logic                           MBOX_CLK,
  input  logic                           CLK,
  input  clkPkg::ebusIn_t                ebus,
  input  logic [clkPkg::cramTimeW-1:0]   cramTime,
  input  logic                           mboxWait,
  input  logic                           mboxResp,
  output clkPkg::ebusOut_t               ebusRd,
  output clkPkg::sectEn_t                sectClk,
  output logic                           eboxSync,
  output clkPkg::runState_t              run
);
  import clkPkg::*;

  // Configuration from the load functions
  clkCfg_t             cfg;

  // Burst nibble loads towards the counter
  logic                loadLo;
  logic                loadHi;
  logic [ldDataW-1:0]  loadData;

  // Single step request, one cycle after the function
  logic                stepPulse;

  // Source tick and burst counter state
  logic                tick;
  logic [burstW-1:0]   burstCount;
  logic                burstZero;

  // Function decode and run state
  diagFuncRegs funcRegs (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .ebus      (ebus),
    .run       (run),
    .cfg       (cfg),
    .loadLo    (loadLo),
    .loadHi    (loadHi),
    .loadData  (loadData),
    .stepPulse (stepPulse)
  );

  burstCounter burstCnt (
    .MBOX_CLK   (MBOX_CLK),
    .CLK        (CLK),
    .loadLo     (loadLo),
    .loadHi     (loadHi),
    .loadData   (loadData),
    .tick       (tick),
    .burst      (run.burst),
    .burstCount (burstCount),
    .burstZero  (burstZero)
  );

  // Rate divider, phase compare and section enables
  eboxSyncDetect syncDetect (
    .MBOX_CLK  (MBOX_CLK),
    .CLK       (CLK),
    .run       (run),
    .cfg       (cfg),
    .stepPulse (stepPulse),
    .burstZero (burstZero),
    .cramTime  (cramTime),
    .mboxWait  (mboxWait),
    .mboxResp  (mboxResp),
    .tick      (tick),
    .eboxSync  (eboxSync),
    .sectClk   (sectClk)
  );

  diagReadMux readMux (
    .ebus       (ebus),
    .run        (run),
    .cfg        (cfg),
    .burstCount (burstCount),
    .burstZero  (burstZero),
    .eboxSync   (eboxSync),
    .ebusRd     (ebusRd)
  );

endmodule

// ==== test/clkBoard_checker.sv ====
`timescale 1ns/1ps

module clkBoard_checker (
  input logic                MBOX_CLK,
  input logic                CLK,
  input logic                eboxSync,
  input clkPkg::sectEn_t     sectClk,
  input clkPkg::runState_t   run,
  input clkPkg::clkCfg_t     cfg
);
  import clkPkg::*;

  // An EBOX clock is a single enable cycle
  sectOneCycle: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    (|sectClk) |=> !(|sectClk))
    else $error("sectClk stayed high for more than one cycle");

  // One sync cycle per request
  syncOneCycle: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    eboxSync |=> !eboxSync)
    else $error("eboxSync stayed high for more than one cycle");

  // No enable while its disable bit is set
  crmMasked: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    sectClk.crm |-> !cfg.crmDis)
    else $error("crm enable raised while crmDis set");

  edpMasked: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    sectClk.edp |-> !cfg.edpDis)
    else $error("edp enable raised while edpDis set");

  ctlMasked: assert property (@(posedge MBOX_CLK) disable iff (CLK)
    sectClk.ctl |-> !cfg.ctlDis)
    else $error("ctl enable raised while ctlDis set");

  // During reset and in the first cycle out of it
  quietAtReset: assert property (@(posedge MBOX_CLK)
    (CLK || $fell(CLK)) |-> (sectClk == '0 && run == 4'b0001))
    else $error("run or sectClk not in reset state");

endmodule

bind clkBoard clkBoard_checker chk (
  .MBOX_CLK (MBOX_CLK),
  .CLK      (CLK),
  .eboxSync (eboxSync),
  .sectClk  (sectClk),
  .run      (run),
  .cfg      (cfg)
);

// ==== test/clkBoardTb.sv ====
`timescale 1ns/1ps

module clkBoardTb;
  import clkPkg::*;

  typedef enum logic [1:0] {opCtl, opLoad, opRead, opRun} opKind_t;

  // One table row, expVal is a read word or an EBOX clock count
  typedef struct packed {
    opKind_t    op;
    logic [2:0] ds;
    logic [3:0] data;
    logic [1:0] cram;
    logic       waitHold;
    logic [7:0] expVal;
    logic [2:0] expEn;
    logic [1:0] rateNow;
  } stimRow_t;

  // Cycles with mboxWait held, and quiet cycles after the last clock
  localparam int holdWin  = 16;
  localparam int quietWin = 12;

  logic                  MBOX_CLK;
  logic                  CLK;
  ebusIn_t               ebus;
  logic [cramTimeW-1:0]  cramTime;
  logic                  mboxWait;
  logic                  mboxResp;
  ebusOut_t              ebusRd;
  sectEn_t               sectClk;
  logic                  eboxSync;
  runState_t             run;

  stimRow_t rows[$];
  int errCount   = 0;
  int badTests   = 0;
  int clocks     = 0;
  int syncs      = 0;
  int cycleCount = 0;
  int cycleLimit = 100000;
  logic [2:0] seenEn;
  logic [1:0] curCram = 2'd0;
  logic [1:0] curRate = 2'd0;

  clkBoard uut (
    .MBOX_CLK (MBOX_CLK),
    .CLK      (CLK),
    .ebus     (ebus),
    .cramTime (cramTime),
    .mboxWait (mboxWait),
    .mboxResp (mboxResp),
    .ebusRd   (ebusRd),
    .sectClk  (sectClk),
    .eboxSync (eboxSync),
    .run      (run)
  );

  initial begin
    MBOX_CLK = 1'b0;
    forever #2 MBOX_CLK = ~MBOX_CLK;
  end

  // Hard stop for a DUT that never finishes a row
  always @(posedge MBOX_CLK) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycleCount);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic checkVal(input string name, input logic [31:0] got,
                          input logic [31:0] expVal);
    if (got !== expVal) begin
      errCount++;
      $display("** Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, expVal, $time);
    end
  endtask

  // Each control row picks a new time field for the clocks it starts
  task automatic addRow(input opKind_t op, input logic [2:0] ds, input logic [3:0] data,
                        input logic waitHold, input logic [7:0] expVal,
                        input logic [2:0] expEn);
    stimRow_t r;
    if (op == opCtl) begin
      curCram = 2'($urandom);
    end
    r = '0;
    r.op = op;
    r.ds = ds;
    r.data = data;
    r.cram = curCram;
    r.waitHold = waitHold;
    r.expVal = expVal;
    r.expEn = expEn;
    r.rateNow = curRate;
    rows.push_back(r);
  endtask

  task automatic buildTable();
    logic [3:0] lo;
    logic [3:0] hi;
    logic [3:0] rate;
    logic [3:0] dis;
    logic [7:0] n;
    logic       zero;
    // Reset state
    addRow(opRead, 3'd0, 4'h0, 1'b0, 8'h04, 3'b000);
    addRow(opRead, 3'd3, 4'h0, 1'b0, 8'h00, 3'b000);
    addRow(opRead, 3'd1, 4'h0, 1'b0, 8'h00, 3'b000);
    addRow(opRead, 3'd2, 4'h0, 1'b0, 8'h00, 3'b000);
    // Random loads read back
    lo = 4'($urandom);
    hi = 4'($urandom);
    rate = 4'($urandom);
    dis = 4'($urandom);
    zero = ({hi, lo} == 8'h00);
    addRow(opLoad, ldBurstLo, lo, 1'b0, 8'h00, 3'b000);
    addRow(opLoad, ldBurstHi, hi, 1'b0, 8'h00, 3'b000);
    addRow(opLoad, ldRate, rate, 1'b0, 8'h00, 3'b000);
    curRate = rate[1:0];
    addRow(opLoad, ldSectDis, dis, 1'b0, 8'h00, 3'b000);
    addRow(opRead, 3'd1, 4'h0, 1'b0, {4'h0, hi}, 3'b000);
    addRow(opRead, 3'd2, 4'h0, 1'b0, {4'h0, lo}, 3'b000);
    addRow(opRead, 3'd3, 4'h0, 1'b0, {2'b00, rate[1:0], dis[2:0], 1'b0}, 3'b000);
    addRow(opRead, 3'd0, 4'h0, 1'b0, {2'b00, 4'b0001, zero, 1'b0}, 3'b000);
    // Reset flop and run state, fnStart request held by mboxWait
    addRow(opLoad, ldRate, 4'h0, 1'b0, 8'h00, 3'b000);
    curRate = 2'd0;
    addRow(opLoad, ldSectDis, 4'h0, 1'b0, 8'h00, 3'b000);
    addRow(opCtl, fnClrReset, 4'h0, 1'b1, 8'h00, 3'b000);
    addRow(opRead, 3'd0, 4'h0, 1'b0, {2'b00, 4'b0000, zero, 1'b0}, 3'b000);
    addRow(opCtl, fnStart, 4'h0, 1'b1, 8'h00, 3'b000);
    addRow(opRead, 3'd0, 4'h0, 1'b0, {2'b00, 4'b1000, zero, 1'b0}, 3'b000);
    addRow(opCtl, fnSetReset, 4'h0, 1'b1, 8'h00, 3'b000);
    addRow(opRead, 3'd0, 4'h0, 1'b0, {2'b00, 4'b0001, zero, 1'b0}, 3'b000);
    addRow(opRun, 3'd0, 4'h0, 1'b1, 8'd1, 3'b111);
    // Burst of N clocks at a random rate
    rate = 4'($urandom);
    n = 8'(1 + ($urandom % 63));
    addRow(opLoad, ldRate, rate, 1'b0, 8'h00, 3'b000);
    curRate = rate[1:0];
    addRow(opLoad, ldBurstLo, n[3:0], 1'b0, 8'h00, 3'b000);
    addRow(opLoad, ldBurstHi, n[7:4], 1'b0, 8'h00, 3'b000);
    addRow(opCtl, fnBurst, 4'h0, 1'b0, 8'h00, 3'b000);
    addRow(opRun, 3'd0, 4'h0, 1'b0, n, 3'b111);
    addRow(opRead, 3'd1, 4'h0, 1'b0, 8'h00, 3'b000);
    addRow(opRead, 3'd2, 4'h0, 1'b0, 8'h00, 3'b000);
    addRow(opRead, 3'd0, 4'h0, 1'b0, 8'b0001_0110, 3'b000);
    // Single steps with the CRM section disabled
    addRow(opLoad, ldSectDis, 4'b0100, 1'b0, 8'h00, 3'b000);
    addRow(opCtl, fnSingleStep, 4'h0, 1'b0, 8'h00, 3'b000);
    addRow(opRun, 3'd0, 4'h0, 1'b0, 8'd1, 3'b011);
    addRow(opCtl, fnEboxSs, 4'h0, 1'b0, 8'h00, 3'b000);
    addRow(opRead, 3'd0, 4'h0, 1'b0, 8'b0000_1110, 3'b000);
    addRow(opRun, 3'd0, 4'h0, 1'b0, 8'd1, 3'b011);
    // Step held by mboxWait, released by one response
    addRow(opLoad, ldSectDis, 4'h0, 1'b0, 8'h00, 3'b000);
    addRow(opCtl, fnSingleStep, 4'h0, 1'b1, 8'h00, 3'b000);
    addRow(opRun, 3'd0, 4'h0, 1'b1, 8'd1, 3'b111);
    addRow(opRead, 3'd3, 4'h0, 1'b0, {2'b00, curRate, 4'b0000}, 3'b000);
  endtask

  // Worst case per clock is rate wait plus up to seven detector cycles
  function automatic int rowBudget(input stimRow_t r);
    if (r.op == opRun) begin
      return int'(r.expVal) * (int'(r.rateNow) + 1 + 3 + 4) + holdWin + quietWin + 16;
    end
    return 3;
  endfunction

  // Outputs are sampled at the falling edge, clear of the registers
  task automatic stepCycle();
    @(negedge MBOX_CLK);
    if (eboxSync) begin
      syncs++;
    end
    if (|sectClk) begin
      clocks++;
      seenEn = seenEn | 3'(sectClk);
    end
  endtask

  task automatic applyRow(input stimRow_t r, input int idx);
    int limit;
    int waited;
    case (r.op)
      opCtl: begin
        cramTime = r.cram;
        mboxWait = r.waitHold;
        mboxResp = 1'b0;
        ebus.ds = r.ds;
        ebus.ctlFunc = 1'b1;
        @(negedge MBOX_CLK);
        ebus.ctlFunc = 1'b0;
      end
      opLoad: begin
        ebus.ds = r.ds;
        ebus.data = r.data;
        ebus.ldFunc = 1'b1;
        @(negedge MBOX_CLK);
        ebus.ldFunc = 1'b0;
      end
      opRead: begin
        ebus.ds = r.ds;
        ebus.readFunc = 1'b1;
        #1;
        checkVal("ebusRd.driving", 32'(ebusRd.driving), 32'd1);
        checkVal("ebusRd.data", 32'(ebusRd.data), 32'(r.expVal));
        // Word 0 carries the run state in bits 5 to 2
        if (r.ds == 3'd0) begin
          checkVal("run", 32'(run), 32'(r.expVal[5:2]));
        end
        @(negedge MBOX_CLK);
        ebus.readFunc = 1'b0;
      end
      default: begin
        cramTime = r.cram;
        clocks = 0;
        syncs = 0;
        seenEn = '0;
        if (r.waitHold) begin
          mboxWait = 1'b1;
          repeat (holdWin) stepCycle();
          checkVal("EBOX clocks under mboxWait", 32'(clocks), 32'd0);
          mboxResp = 1'b1;
          stepCycle();
          mboxResp = 1'b0;
        end
        mboxWait = 1'b0;
        limit = int'(r.expVal) * (int'(r.rateNow) + 8) + 8;
        waited = 0;
        while (clocks < int'(r.expVal) && waited < limit) begin
          stepCycle();
          waited++;
        end
        if (clocks < int'(r.expVal)) begin
          $display("Row %0d: EBOX clocks stopped at %0d, none more in %0d cycles",
                   idx, clocks, limit);
        end
        // Nothing more may follow the expected clocks
        repeat (quietWin) stepCycle();
        checkVal("EBOX clock count", 32'(clocks), 32'(r.expVal));
        // One sync pulse ahead of every EBOX clock
        checkVal("eboxSync pulses", 32'(syncs), 32'(r.expVal));
        checkVal("sectClk enables seen", 32'(seenEn), 32'(r.expEn));
      end
    endcase
  endtask

  initial begin
    int errBefore;
    void'($urandom(32'hf774_f99b));
    CLK = 1'b1;
    ebus = '0;
    cramTime = '0;
    mboxWait = 1'b0;
    mboxResp = 1'b0;
    seenEn = '0;
    buildTable();
    cycleLimit = 100;
    foreach (rows[i]) begin
      cycleLimit += rowBudget(rows[i]);
    end
    repeat (2) @(negedge MBOX_CLK);
    CLK = 1'b0;
    foreach (rows[i]) begin
      errBefore = errCount;
      applyRow(rows[i], i);
      if (errCount != errBefore) begin
        badTests++;
      end
      $display("Row %0d %s ds=%0d: %s", i, rows[i].op.name(), rows[i].ds,
               (errCount == errBefore) ? "ok" : "mismatch");
    end
    $display("Summary: %0d rows, %0d with mismatches, %0d errors",
             rows.size(), badTests, errCount);
    if (errCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/clkPkg.sv
hw/diagFuncRegs.sv
hw/burstCounter.sv
hw/eboxSyncDetect.sv
hw/diagReadMux.sv
hw/clkBoard.sv
test/clkBoard_checker.sv
test/clkBoardTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the clock board testbench with Verilator and runs it once
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module clkBoardTb -f vlog.f -o clkBoardSim \
  && simOut="$(./obj_dir/clkBoardSim)" \
  && echo "$simOut" \
  && echo "$simOut" | grep -q "Result: PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
